//--- verilog/tile_bus_pkg.sv
`default_nettype none

package tile_bus_pkg;

   // Shared tile bus geometry
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int SEL_W  = DATA_W / 8;   // One select bit per byte lane

   typedef logic [ADDR_W-1:0] wb_addr_t;
   typedef logic [DATA_W-1:0] wb_data_t;
   typedef logic [SEL_W-1:0]  wb_sel_t;

   // Arbiter ownership states
   typedef enum logic [1:0] {
      IDLE,     // Nobody owns the shared bus
      OWN_M0,   // Instruction side holds the bus
      OWN_M1    // Data side holds the bus
   } arb_state_e;

endpackage

`default_nettype wire

//--- verilog/tile_map_pkg.sv
`default_nettype none

package tile_map_pkg;

   import tile_bus_pkg::*;

   // Region is the top address nibble
   localparam int REGION_W   = 4;
   localparam int REGION_LSB = 28;

   typedef enum logic [REGION_W-1:0] {
      REG_LMEM = 4'h0,   // Local SRAM
      REG_EXT  = 4'hE,   // External memory port
      REG_BOOT = 4'hF    // Boot ROM
   } region_e;

   localparam int BOOT_WORDS = 8;

   // Boot stub that jumps into local memory
   localparam wb_data_t [0:BOOT_WORDS-1] BOOT_ROM = '{
      32'h1820_0000,   // Load upper half of stack pointer
      32'hA821_3FFC,   // Stack top inside local memory
      32'h1860_0000,   // Entry point upper half
      32'hA863_0100,   // Entry point lower half
      32'h4400_1800,   // Jump to entry
      32'h1500_0000,   // Delay slot
      32'h0000_0000,
      32'hB007_C0DE    // Table signature
   };

endpackage

`default_nettype wire

//--- verilog/wb_if.sv
`default_nettype none

interface wb_if import tile_bus_pkg::*; ();

   logic     cyc;
   logic     stb;
   logic     we;
   wb_addr_t adr;
   wb_sel_t  sel;
   wb_data_t dat_w;   // Master to slave
   wb_data_t dat_r;   // Slave to master
   logic     ack;
   logic     err;

   modport master (
      output cyc, stb, we, adr, sel, dat_w,
      input  dat_r, ack, err
   );

   modport slave (
      input  cyc, stb, we, adr, sel, dat_w,
      output dat_r, ack, err
   );

endinterface

`default_nettype wire

//--- verilog/wb_arbiter.sv
`default_nettype none

module wb_arbiter import tile_bus_pkg::*; (
   input  logic clk,
   input  logic rst_i,
   wb_if.slave  m0,
   wb_if.slave  m1,
   wb_if.master bus
);

   arb_state_e state_q;
   arb_state_e state_d;
   logic       prio_m1_q;   // Next tie goes to master 1
   logic       bus_free;
   logic       grant_m0;
   logic       grant_m1;
   logic       owner_m1;
   logic       granted;

   // Free once the owner has let go of cyc
   assign bus_free = (state_q == IDLE) ||
                     (state_q == OWN_M0 && !m0.cyc) ||
                     (state_q == OWN_M1 && !m1.cyc);

   always_comb begin
      if (m0.cyc && m1.cyc) begin
         grant_m0 = !prio_m1_q;   // Tie resolved by history
         grant_m1 = prio_m1_q;
      end else begin
         grant_m0 = m0.cyc;
         grant_m1 = m1.cyc;
      end
   end

   always_comb begin
      state_d = state_q;
      if (bus_free) begin
         if (grant_m0)
            state_d = OWN_M0;
         else if (grant_m1)
            state_d = OWN_M1;
         else
            state_d = IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q   <= IDLE;
         prio_m1_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (bus_free && grant_m0)
            prio_m1_q <= 1'b1;
         else if (bus_free && grant_m1)
            prio_m1_q <= 1'b0;
      end
   end

   assign owner_m1 = (state_q == OWN_M1);
   assign granted  = (state_q != IDLE);

   // Owner request goes straight through
   assign bus.cyc   = granted && (owner_m1 ? m1.cyc : m0.cyc);
   assign bus.stb   = granted && (owner_m1 ? m1.stb : m0.stb);
   assign bus.we    = owner_m1 ? m1.we    : m0.we;
   assign bus.adr   = owner_m1 ? m1.adr   : m0.adr;
   assign bus.sel   = owner_m1 ? m1.sel   : m0.sel;
   assign bus.dat_w = owner_m1 ? m1.dat_w : m0.dat_w;

   // Waiting master sees a silent bus
   assign m0.ack   = (state_q == OWN_M0) && bus.ack;
   assign m0.err   = (state_q == OWN_M0) && bus.err;
   assign m0.dat_r = bus.dat_r;
   assign m1.ack   = owner_m1 && bus.ack;
   assign m1.err   = owner_m1 && bus.err;
   assign m1.dat_r = bus.dat_r;

   // A responded master still holds its cycle
   a_resp_m0_owner : assert property (@(posedge clk) disable iff (rst_i)
      (m0.ack || m0.err) |-> m0.cyc);
   a_resp_m1_owner : assert property (@(posedge clk) disable iff (rst_i)
      (m1.ack || m1.err) |-> m1.cyc);

endmodule

`default_nettype wire

//--- verilog/wb_addr_decoder.sv
`default_nettype none

module wb_addr_decoder import tile_map_pkg::*; (
   input  logic clk,
   input  logic rst_i,
   wb_if.slave  bus,
   wb_if.master lmem,
   wb_if.master boot,
   wb_if.master ext
);

   region_e region;
   logic    hit_lmem;
   logic    hit_boot;
   logic    hit_ext;
   logic    unmapped;
   logic    req;
   logic    err_q;

   assign region   = region_e'(bus.adr[REGION_LSB +: REGION_W]);
   assign hit_lmem = (region == REG_LMEM);
   assign hit_boot = (region == REG_BOOT);
   assign hit_ext  = (region == REG_EXT);
   assign unmapped = !(hit_lmem || hit_boot || hit_ext);
   assign req      = bus.cyc && bus.stb;

   // Only the selected slave sees cyc and stb
   assign lmem.cyc   = bus.cyc && hit_lmem;
   assign lmem.stb   = bus.stb && hit_lmem;
   assign lmem.we    = bus.we;
   assign lmem.adr   = bus.adr;
   assign lmem.sel   = bus.sel;
   assign lmem.dat_w = bus.dat_w;

   assign boot.cyc   = bus.cyc && hit_boot;
   assign boot.stb   = bus.stb && hit_boot;
   assign boot.we    = bus.we;
   assign boot.adr   = bus.adr;
   assign boot.sel   = bus.sel;
   assign boot.dat_w = bus.dat_w;

   assign ext.cyc    = bus.cyc && hit_ext;
   assign ext.stb    = bus.stb && hit_ext;
   assign ext.we     = bus.we;
   assign ext.adr    = bus.adr;
   assign ext.sel    = bus.sel;
   assign ext.dat_w  = bus.dat_w;

   // Unmapped cycle gets a single err pulse
   always_ff @(posedge clk) begin
      if (rst_i)
         err_q <= 1'b0;
      else
         err_q <= req && unmapped && !err_q;
   end

   always_comb begin
      case (region)
         REG_LMEM: bus.dat_r = lmem.dat_r;
         REG_BOOT: bus.dat_r = boot.dat_r;
         REG_EXT:  bus.dat_r = ext.dat_r;
         default:  bus.dat_r = '0;
      endcase
   end

   assign bus.ack = (hit_lmem && lmem.ack) ||
                    (hit_boot && boot.ack) ||
                    (hit_ext  && ext.ack);
   assign bus.err = err_q ||
                    (hit_lmem && lmem.err) ||
                    (hit_boot && boot.err) ||
                    (hit_ext  && ext.err);

   // At most one source answers the shared bus
   a_one_slave : assert property (@(posedge clk) disable iff (rst_i)
      $onehot0({lmem.ack, boot.ack, boot.err, ext.ack, ext.err, err_q}));

endmodule

`default_nettype wire

//--- verilog/wb_sram_slave.sv
`default_nettype none

module wb_sram_slave import tile_bus_pkg::*; #(
   parameter int LMEM_WORDS = 1024
) (
   input  logic clk,
   input  logic rst_i,
   wb_if.slave  bus
);

   localparam int IDX_W = $clog2(LMEM_WORDS);

   wb_data_t         mem [LMEM_WORDS];
   wb_data_t         dat_q;
   logic             ack_q;
   logic             take;
   logic [IDX_W-1:0] idx;

   assign idx  = bus.adr[IDX_W+1:2];   // Word address, wraps above depth
   assign take = bus.cyc && bus.stb && !ack_q;

   always_ff @(posedge clk) begin
      if (rst_i)
         ack_q <= 1'b0;
      else
         ack_q <= take;
   end

   // Storage and read data
   always_ff @(posedge clk) begin
      if (take) begin
         if (bus.we) begin
            for (int b = 0; b < SEL_W; b++) begin
               if (bus.sel[b])
                  mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
            end
         end else begin
            dat_q <= mem[idx];
         end
      end
   end

   assign bus.ack   = ack_q;
   assign bus.err   = 1'b0;   // Every local word is mapped
   assign bus.dat_r = dat_q;

   // Master still holds its request when acked
   a_ack_in_cycle : assert property (@(posedge clk) disable iff (rst_i)
      bus.ack |-> bus.cyc && bus.stb);

endmodule

`default_nettype wire

//--- verilog/bootrom_slave.sv
`default_nettype none

module bootrom_slave import tile_bus_pkg::*, tile_map_pkg::*; (
   input  logic clk,
   input  logic rst_i,
   wb_if.slave  bus
);

   localparam int ROM_IDX_W = $clog2(BOOT_WORDS);

   wb_data_t             dat_q;
   logic                 ack_q;
   logic                 err_q;
   logic                 take;
   logic [ROM_IDX_W-1:0] idx;

   assign idx  = bus.adr[ROM_IDX_W+1:2];   // Whole region aliases onto table
   assign take = bus.cyc && bus.stb && !(ack_q || err_q);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= take && !bus.we;
         err_q <= take && bus.we;   // Read only
      end
   end

   always_ff @(posedge clk) begin
      if (take)
         dat_q <= BOOT_ROM[idx];
   end

   assign bus.ack   = ack_q;
   assign bus.err   = err_q;
   assign bus.dat_r = dat_q;

endmodule

`default_nettype wire

//--- verilog/compute_tile_bus.sv
`default_nettype none

module compute_tile_bus import tile_bus_pkg::*; #(
   parameter int LMEM_WORDS = 1024
) (
   input  logic     clk,
   input  logic     rst_i,

   // Instruction side master
   input  logic     m0_cyc_i,
   input  logic     m0_stb_i,
   input  logic     m0_we_i,
   input  wb_addr_t m0_adr_i,
   input  wb_sel_t  m0_sel_i,
   input  wb_data_t m0_dat_i,
   output wb_data_t m0_dat_o,
   output logic     m0_ack_o,
   output logic     m0_err_o,

   // Data side master
   input  logic     m1_cyc_i,
   input  logic     m1_stb_i,
   input  logic     m1_we_i,
   input  wb_addr_t m1_adr_i,
   input  wb_sel_t  m1_sel_i,
   input  wb_data_t m1_dat_i,
   output wb_data_t m1_dat_o,
   output logic     m1_ack_o,
   output logic     m1_err_o,

   // External memory port
   output logic     ext_cyc_o,
   output logic     ext_stb_o,
   output logic     ext_we_o,
   output wb_addr_t ext_adr_o,
   output wb_sel_t  ext_sel_o,
   output wb_data_t ext_dat_o,
   input  wb_data_t ext_dat_i,
   input  logic     ext_ack_i,
   input  logic     ext_err_i
);

   wb_if m0_bus ();
   wb_if m1_bus ();
   wb_if shared_bus ();
   wb_if lmem_bus ();
   wb_if boot_bus ();
   wb_if ext_bus ();

   assign m0_bus.cyc   = m0_cyc_i;
   assign m0_bus.stb   = m0_stb_i;
   assign m0_bus.we    = m0_we_i;
   assign m0_bus.adr   = m0_adr_i;
   assign m0_bus.sel   = m0_sel_i;
   assign m0_bus.dat_w = m0_dat_i;
   assign m0_dat_o     = m0_bus.dat_r;
   assign m0_ack_o     = m0_bus.ack;
   assign m0_err_o     = m0_bus.err;

   assign m1_bus.cyc   = m1_cyc_i;
   assign m1_bus.stb   = m1_stb_i;
   assign m1_bus.we    = m1_we_i;
   assign m1_bus.adr   = m1_adr_i;
   assign m1_bus.sel   = m1_sel_i;
   assign m1_bus.dat_w = m1_dat_i;
   assign m1_dat_o     = m1_bus.dat_r;
   assign m1_ack_o     = m1_bus.ack;
   assign m1_err_o     = m1_bus.err;

   // External slave is a plain pass-through
   assign ext_cyc_o     = ext_bus.cyc;
   assign ext_stb_o     = ext_bus.stb;
   assign ext_we_o      = ext_bus.we;
   assign ext_adr_o     = ext_bus.adr;
   assign ext_sel_o     = ext_bus.sel;
   assign ext_dat_o     = ext_bus.dat_w;
   assign ext_bus.dat_r = ext_dat_i;
   assign ext_bus.ack   = ext_ack_i;
   assign ext_bus.err   = ext_err_i;

   wb_arbiter u_arbiter (
      .clk   (clk),
      .rst_i (rst_i),
      .m0    (m0_bus.slave),
      .m1    (m1_bus.slave),
      .bus   (shared_bus.master)
   );

   wb_addr_decoder u_decoder (
      .clk   (clk),
      .rst_i (rst_i),
      .bus   (shared_bus.slave),
      .lmem  (lmem_bus.master),
      .boot  (boot_bus.master),
      .ext   (ext_bus.master)
   );

   wb_sram_slave #(
      .LMEM_WORDS (LMEM_WORDS)
   ) u_lmem (
      .clk   (clk),
      .rst_i (rst_i),
      .bus   (lmem_bus.slave)
   );

   bootrom_slave u_bootrom (
      .clk   (clk),
      .rst_i (rst_i),
      .bus   (boot_bus.slave)
   );

endmodule

`default_nettype wire

//--- sim/tb_compute_tile_bus.sv
`default_nettype none

module tb_compute_tile_bus import tile_bus_pkg::*, tile_map_pkg::*; ();

   localparam int LMEM_WORDS = 256;

   typedef enum logic [1:0] {RESP_NONE, RESP_ACK, RESP_ERR} resp_e;

   logic     clk;
   logic     rst_i;
   logic     m0_cyc_i, m0_stb_i, m0_we_i, m1_cyc_i, m1_stb_i, m1_we_i;
   wb_addr_t m0_adr_i, m1_adr_i, ext_adr_o;
   wb_sel_t  m0_sel_i, m1_sel_i, ext_sel_o;
   wb_data_t m0_dat_i, m0_dat_o, m1_dat_i, m1_dat_o, ext_dat_o, ext_dat_i;
   logic     m0_ack_o, m0_err_o, m1_ack_o, m1_err_o;
   logic     ext_cyc_o, ext_stb_o, ext_we_o, ext_ack_i, ext_err_i;

   logic [31:0] lfsr_q;
   int          errors;
   int          checks;
   int          test_base;
   wb_data_t    ext_mem [64];
   logic        ext_vld [64];
   wb_addr_t    seen_adr;   // Last request captured on the ext port
   wb_sel_t     seen_sel;
   logic        seen_we;
   wb_data_t    seen_dat;

   compute_tile_bus #(.LMEM_WORDS(LMEM_WORDS)) dut (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic wb_data_t rand_bits(input int n);
      wb_data_t r;
      logic     fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r      = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic wb_data_t ext_fill(input wb_addr_t adr);
      return {adr[15:0], adr[31:16]} ^ 32'hC3C3_3C3C;   // Unwritten ext words
   endfunction

   // External memory with a random 1 to 4 cycle ack delay
   initial begin : ext_model
      int delay;
      ext_ack_i = 1'b0;
      ext_err_i = 1'b0;
      ext_dat_i = '0;
      forever begin
         @(negedge clk);
         if (ext_cyc_o && ext_stb_o) begin
            seen_adr = ext_adr_o;
            seen_sel = ext_sel_o;
            seen_we  = ext_we_o;
            seen_dat = ext_dat_o;
            delay    = 1 + int'(rand_bits(2));
            repeat (delay) @(posedge clk);
            #1;
            if (seen_we) begin
               ext_mem[seen_adr[7:2]] = seen_dat;
               ext_vld[seen_adr[7:2]] = 1'b1;
            end else begin
               ext_dat_i = ext_vld[seen_adr[7:2]] ? ext_mem[seen_adr[7:2]]
                                                  : ext_fill(seen_adr);
            end
            ext_ack_i = 1'b1;
            @(posedge clk);
            #1 ext_ack_i = 1'b0;
         end
      end
   end

   task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s: got 0x%08h expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input wb_addr_t got, input wb_addr_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s: got 0x%08h expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic check_sel(input string name, input wb_sel_t got, input wb_sel_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s: got 0x%01h expected 0x%01h", name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s: got 0x%01h expected 0x%01h", name, got, exp);
      end
   endtask

   task automatic check_resp(input string name, input resp_e got, input resp_e exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("%s ended with %s where %s was expected", name, got.name(), exp.name());
      end
   endtask

   task automatic drive_master(input int m, input logic req, input logic we,
                               input wb_addr_t adr, input wb_sel_t sel, input wb_data_t dat);
      if (m == 0) begin
         {m0_cyc_i, m0_stb_i, m0_we_i} = {req, req, we};
         m0_adr_i = adr;
         m0_sel_i = sel;
         m0_dat_i = dat;
      end else begin
         {m1_cyc_i, m1_stb_i, m1_we_i} = {req, req, we};
         m1_adr_i = adr;
         m1_sel_i = sel;
         m1_dat_i = dat;
      end
   endtask

   // Called 1 unit after a rising edge, returns at the same phase
   task automatic wb_access(input int m, input logic we, input wb_addr_t adr, input wb_sel_t sel,
                            input wb_data_t dat, output wb_data_t rdat, output resp_e resp);
      int   n;
      logic ack;
      logic err;
      n    = 0;
      resp = RESP_NONE;
      rdat = '0;
      drive_master(m, 1'b1, we, adr, sel, dat);
      do begin
         @(negedge clk);
         ack = (m == 0) ? m0_ack_o : m1_ack_o;
         err = (m == 0) ? m0_err_o : m1_err_o;
         n++;
      end while (!ack && !err && n < 100);
      if (ack || err) begin
         resp = ack ? RESP_ACK : RESP_ERR;
         rdat = (m == 0) ? m0_dat_o : m1_dat_o;
      end else begin
         errors++;
         $display("master %0d saw neither ack nor err within 100 cycles at 0x%08h", m, adr);
      end
      @(posedge clk);
      #1 drive_master(m, 1'b0, 1'b0, '0, '0, '0);
      @(posedge clk);   // Idle edge lets the arbiter release the bus
      #1;
   endtask

   task automatic report_test(input string name);
      $display("test %s finished with %0d errors", name, errors - test_base);
      test_base = errors;
   endtask

   task automatic test_local_memory();
      wb_addr_t adr [8];
      wb_data_t dat [8];
      wb_data_t r;
      resp_e    rsp;
      for (int i = 0; i < 8; i++) begin
         r      = rand_bits(5);
         adr[i] = {22'h0, 3'(i), r[4:0], 2'b00};   // Distinct words
         dat[i] = rand_bits(32);
         wb_access(0, 1'b1, adr[i], 4'hF, dat[i], r, rsp);
         check_resp("lmem write", rsp, RESP_ACK);
      end
      for (int i = 0; i < 8; i++) begin
         wb_access(0, 1'b0, adr[i], 4'hF, '0, r, rsp);
         check_resp("lmem read", rsp, RESP_ACK);
         check_data("m0_dat_o", r, dat[i]);
      end
      report_test("local_memory");
   endtask

   task automatic test_byte_lanes();
      wb_data_t w;
      wb_data_t b;
      wb_data_t r;
      resp_e    rsp;
      w = rand_bits(32);
      b = rand_bits(32);   // Only lane 2 of this may land
      wb_access(0, 1'b1, 32'h0000_0040, 4'hF, w, r, rsp);
      wb_access(0, 1'b1, 32'h0000_0040, 4'b0100, b, r, rsp);
      wb_access(0, 1'b0, 32'h0000_0040, 4'hF, '0, r, rsp);
      check_resp("lane read", rsp, RESP_ACK);
      check_data("m0_dat_o", r, {w[31:24], b[23:16], w[15:0]});
      report_test("byte_lanes");
   endtask

   task automatic test_boot_rom();
      wb_addr_t adr;
      wb_data_t r;
      resp_e    rsp;
      for (int i = 0; i < 8; i++) begin
         r   = rand_bits(26);
         adr = {4'hF, r[25:0], 2'b00};
         wb_access(0, 1'b0, adr, 4'hF, '0, r, rsp);
         check_resp("boot read", rsp, RESP_ACK);
         check_data("m0_dat_o", r, BOOT_ROM[adr[4:2]]);
      end
      wb_access(0, 1'b1, 32'hF000_0008, 4'hF, 32'h1234_5678, r, rsp);
      check_resp("boot write", rsp, RESP_ERR);
      report_test("boot_rom");
   endtask

   task automatic test_external();
      wb_addr_t adr;
      wb_sel_t  s;
      wb_data_t d;
      wb_data_t r;
      resp_e    rsp;
      for (int i = 0; i < 4; i++) begin
         r   = rand_bits(26);
         adr = {4'hE, r[25:0], 2'b00};
         d   = rand_bits(32);
         r   = rand_bits(4);
         s   = r[3:0];   // Lanes only pass through here
         wb_access(1, 1'b1, adr, s, d, r, rsp);
         check_resp("ext write", rsp, RESP_ACK);
         check_addr("ext_adr_o", seen_adr, adr);
         check_sel("ext_sel_o", seen_sel, s);
         check_flag("ext_we_o", seen_we, 1'b1);
         check_data("ext_dat_o", seen_dat, d);
         wb_access(1, 1'b0, adr, 4'hF, '0, r, rsp);
         check_resp("ext read", rsp, RESP_ACK);
         check_addr("ext_adr_o", seen_adr, adr);
         check_sel("ext_sel_o", seen_sel, 4'hF);
         check_flag("ext_we_o", seen_we, 1'b0);
         check_data("m1_dat_o", r, d);
      end
      report_test("external");
   endtask

   task automatic test_unmapped();
      wb_data_t r;
      resp_e    rsp;
      wb_access(1, 1'b0, 32'h5000_0010, 4'hF, '0, r, rsp);
      check_resp("unmapped read", rsp, RESP_ERR);
      report_test("unmapped");
   endtask

   // Last owner was master 1, so the tie goes to master 0
   task automatic test_arbitration();
      wb_data_t d0, d1, r0, r1;
      resp_e    s0, s1;
      time      t0, t1;
      d0 = rand_bits(32);
      d1 = rand_bits(32);
      wb_access(0, 1'b1, 32'h0000_0100, 4'hF, d0, r0, s0);
      wb_access(1, 1'b1, 32'h0000_0200, 4'hF, d1, r1, s1);
      fork
         begin
            wb_access(0, 1'b0, 32'h0000_0100, 4'hF, '0, r0, s0);
            t0 = $time;
         end
         begin
            wb_access(1, 1'b0, 32'h0000_0200, 4'hF, '0, r1, s1);
            t1 = $time;
         end
      join
      check_resp("m0 tie read", s0, RESP_ACK);
      check_resp("m1 tie read", s1, RESP_ACK);
      check_data("m0_dat_o", r0, d0);
      check_data("m1_dat_o", r1, d1);
      check_flag("m0_first", t0 < t1, 1'b1);
      report_test("arbitration");
   endtask

   initial begin
      lfsr_q    = 32'h1;
      errors    = 0;
      checks    = 0;
      test_base = 0;
      for (int i = 0; i < 64; i++)
         ext_vld[i] = 1'b0;
      rst_i = 1'b1;
      drive_master(0, 1'b0, 1'b0, '0, '0, '0);
      drive_master(1, 1'b0, 1'b0, '0, '0, '0);
      repeat (4) @(posedge clk);
      #1 rst_i = 1'b0;
      check_flag("m0_ack_o", m0_ack_o, 1'b0);   // Quiet bus out of reset
      check_flag("m0_err_o", m0_err_o, 1'b0);
      check_flag("m1_ack_o", m1_ack_o, 1'b0);
      check_flag("m1_err_o", m1_err_o, 1'b0);
      check_flag("ext_cyc_o", ext_cyc_o, 1'b0);
      test_local_memory();
      test_byte_lanes();
      test_boot_rom();
      test_external();
      test_unmapped();
      test_arbitration();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
verilog/tile_bus_pkg.sv
verilog/tile_map_pkg.sv
verilog/wb_if.sv
verilog/wb_arbiter.sv
verilog/wb_addr_decoder.sv
verilog/wb_sram_slave.sv
verilog/bootrom_slave.sv
verilog/compute_tile_bus.sv
sim/tb_compute_tile_bus.sv

//--- Bender.yml
package:
  name: compute_tile_bus

sources:
  - verilog/tile_bus_pkg.sv
  - verilog/tile_map_pkg.sv
  - verilog/wb_if.sv
  - verilog/wb_arbiter.sv
  - verilog/wb_addr_decoder.sv
  - verilog/wb_sram_slave.sv
  - verilog/bootrom_slave.sv
  - verilog/compute_tile_bus.sv
  - target: test
    files:
      - sim/tb_compute_tile_bus.sv
